// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module tb_adc_control -f tb.f -o Vtb_adc_control

run: build
	./obj_dir/Vtb_adc_control | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only -Wall --top-module adc_control_top \
		common/adc_pkg.sv adc/adc_serial_link.sv rtl/frame_fifo.sv \
		adc/adc_sample_bank.sv rtl/adc_reg_bus.sv rtl/adc_control_top.sv

clean:
	rm -rf obj_dir sim.log

// File: adc/adc_sample_bank.sv
`timescale 1ns/1ns

module adc_sample_bank
    import adc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  logic              frame_valid,
    output logic              frame_ready,
    input  frame_t            frame_data,
    input  logic              rate_wr,
    input  logic [CHAN_W-1:0] rate_chan,
    input  logic [RATE_W-1:0] rate_value,
    input  logic [CHAN_W-1:0] rd_chan,
    output frame_t            rd_sample,
    output logic [SEQ_W-1:0]  rd_seq
);

    // newest frame seen per channel
    frame_t            latest [NUM_CHANNELS];
    // published values gathered for the read port
    frame_t            sample_arr [NUM_CHANNELS];
    logic [SEQ_W-1:0]  seq_arr [NUM_CHANNELS];
    logic [CHAN_W-1:0] in_chan;
    logic              take;

    // channel sits in the top bits of the frame
    assign in_chan = frame_data[FRAME_BITS-1 -: CHAN_W];
    assign take    = frame_valid & frame_ready;

    // ready from the first cycle after reset on
    always_ff @(posedge clk) begin
        frame_ready <= ~reset;
    end

    // --------------------------------------------------
    // latest frame per channel
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                latest[i] <= '0;
            end
        end else if (take) begin
            latest[in_chan] <= frame_data;
        end
    end

    // --------------------------------------------------
    // per channel rate counter and published sample
    // --------------------------------------------------
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        logic [RATE_W-1:0] rate_q;
        logic [RATE_W-1:0] cnt_q;
        frame_t            sample_q;
        logic [SEQ_W-1:0]  seq_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                rate_q   <= '0;
                cnt_q    <= RATE_W'(1);
                sample_q <= '0;
                seq_q    <= '0;
            end else begin
                if (rate_wr && rate_chan == CHAN_W'(ch)) begin
                    rate_q <= rate_value;
                end
                // park the counter at one while stopped or at rate zero
                if (!run || rate_q == '0) begin
                    cnt_q <= RATE_W'(1);
                end else if (cnt_q >= rate_q) begin
                    // on overflow publish and bump the sequence on the same edge
                    cnt_q    <= RATE_W'(1);
                    sample_q <= latest[ch];
                    seq_q    <= seq_q + 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end

        assign sample_arr[ch] = sample_q;
        assign seq_arr[ch]    = seq_q;
    end

    // combinational read port, registered in the bus
    assign rd_sample = sample_arr[rd_chan];
    assign rd_seq    = seq_arr[rd_chan];

endmodule

// File: adc/adc_serial_link.sv
`timescale 1ns/1ns

module adc_serial_link
    import adc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_valid,
    input  logic [15:0] cmd_word,
    output logic        cmd_ready,
    output logic        frame_valid,
    output frame_t      frame_data,
    input  logic        frame_ready,
    output logic        adc_cs_n,
    output logic        adc_sclk,
    output logic        adc_din,
    input  logic        adc_dout
);

    logic [LINK_STATES-1:0] state;
    logic [DIV_W-1:0]       div_cnt;
    logic [BIT_W-1:0]       bit_cnt;
    logic                   sclk_q;
    logic [FRAME_BITS-1:0]  shift_out;
    frame_t                 shift_in;
    logic                   valid_q;

    logic shifting;
    logic tick;
    logic rise;
    logic fall;
    logic last_fall;
    logic gap_done;
    logic can_start;
    logic go;

    // --------------------------------------------------
    // sclk edges
    // --------------------------------------------------
    // sclk idles low, so every transfer opens with a low half period
    // the chip must show its msb as soon as cs_n falls
    assign shifting  = state[ST_CMD] | state[ST_READ];
    assign tick      = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign rise      = shifting & tick & ~sclk_q;
    assign fall      = shifting & tick & sclk_q;
    // falling edge after the 16th rising edge closes the transfer
    assign last_fall = fall & (bit_cnt == BIT_W'(FRAME_BITS));
    // gap lasts one full sclk period of two ticks
    assign gap_done  = state[ST_GAP] & tick & (bit_cnt == BIT_W'(1));
    assign can_start = gap_done | state[ST_OFFER];
    // no new transfer while the last frame is still offered
    assign go        = can_start & ~valid_q;
    assign cmd_ready = go;

    // --------------------------------------------------
    // one-hot FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= '0;
            state[ST_GAP] <= 1'b1;
        end else if (go) begin
            state <= '0;
            // a pending command wins over a read
            if (cmd_valid) begin
                state[ST_CMD] <= 1'b1;
            end else begin
                state[ST_READ] <= 1'b1;
            end
        end else if (gap_done) begin
            // hold cs_n high until the frame is taken
            state           <= '0;
            state[ST_OFFER] <= 1'b1;
        end else if (last_fall) begin
            state         <= '0;
            state[ST_GAP] <= 1'b1;
        end
    end

    // divider, bit counter and sclk level
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
        end else begin
            if (go || tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // counts rising edges in a transfer and ticks in the gap
            if (go || last_fall) begin
                bit_cnt <= '0;
            end else if (rise || (state[ST_GAP] && tick)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (rise) begin
                sclk_q <= 1'b1;
            end else if (fall) begin
                sclk_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // shift registers
    // --------------------------------------------------
    // din changes on falling edges and a read shifts out zeros
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_out <= '0;
        end else if (go) begin
            shift_out <= cmd_valid ? cmd_word : '0;
        end else if (fall) begin
            shift_out <= {shift_out[FRAME_BITS-2:0], 1'b0};
        end
    end

    // dout sampled msb first on rising edges
    always_ff @(posedge clk) begin
        if (rise && state[ST_READ]) begin
            shift_in <= {shift_in[FRAME_BITS-2:0], adc_dout};
        end
    end

    // offer the frame on the cycle after the last rising edge
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (rise && state[ST_READ] && bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
            valid_q <= 1'b1;
        end else if (frame_ready) begin
            valid_q <= 1'b0;
        end
    end

    assign frame_valid = valid_q;
    // shift_in is frozen until the frame is taken
    assign frame_data  = shift_in;
    assign adc_cs_n    = ~shifting;
    assign adc_sclk    = sclk_q;
    assign adc_din     = shift_out[FRAME_BITS-1];

endmodule

// File: common/adc_pkg.sv
package adc_pkg;

    // --------------------------------------------------
    // frame and channel layout
    // --------------------------------------------------

    // one adc frame with the channel in bits 15..13 and the whole word kept as the sample
    typedef logic [15:0] frame_t;

    localparam int NUM_CHANNELS = 8;
    localparam int CHAN_W       = 3;
    localparam int FRAME_BITS   = 16;
    localparam int RATE_W       = 32;
    localparam int SEQ_W        = 16;

    // --------------------------------------------------
    // serial link timing
    // --------------------------------------------------

    // clk cycles per half period of adc_sclk
    localparam int SCLK_DIV    = 2;
    localparam int DIV_W       = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    // bit counter must reach FRAME_BITS
    localparam int BIT_W       = $clog2(FRAME_BITS + 1);
    // clk cycles with cs_n low for one transfer
    localparam int XFER_CYCLES = FRAME_BITS * 2 * SCLK_DIV;
    localparam int BUSY_W      = $clog2(XFER_CYCLES + 1);

    // one-hot state bit positions of the link FSM
    localparam int ST_GAP      = 0;
    localparam int ST_CMD      = 1;
    localparam int ST_READ     = 2;
    localparam int ST_OFFER    = 3;
    localparam int LINK_STATES = 4;

    // --------------------------------------------------
    // frame fifo
    // --------------------------------------------------
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------------------
    // register map, low address byte
    // --------------------------------------------------
    localparam logic [7:0] REG_PROGRAM  = 8'h04;
    localparam logic [7:0] REG_SAMPLE   = 8'h07;
    localparam logic [7:0] REG_SEQUENCE = 8'h08;
    localparam logic [7:0] REG_ID       = 8'h09;
    localparam logic [7:0] REG_LAST     = 8'h0B;
    localparam logic [7:0] REG_RATE     = 8'h0D;

    localparam logic [15:0] ID_VALUE      = 16'h0ADC;
    // upper half of a PROGRAM word that marks a real command
    localparam logic [15:0] CMD_NEW_VALUE = 16'd1;

endpackage

// File: rtl/adc_control_top.sv
`timescale 1ns/1ns

module adc_control_top
    import adc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] addr,
    input  logic [31:0] wdata,
    input  logic        wr,
    input  logic        re,
    output logic [15:0] data_out,
    output logic        busy,
    input  logic        run,
    output logic        adc_cs_n,
    output logic        adc_sclk,
    output logic        adc_din,
    input  logic        adc_dout
);

    // --------------------------------------------------
    // internal connections
    // --------------------------------------------------
    // command hand-off, bus to link
    logic              cmd_valid;
    logic              cmd_ready;
    logic [15:0]       cmd_word;
    // link to fifo
    logic              link_valid;
    logic              link_ready;
    frame_t            link_data;
    // fifo to bank
    logic              bank_valid;
    logic              bank_ready;
    frame_t            bank_data;
    // rate writes and read port
    logic              rate_wr;
    logic [CHAN_W-1:0] rate_chan;
    logic [RATE_W-1:0] rate_value;
    logic [CHAN_W-1:0] rd_chan;
    frame_t            rd_sample;
    logic [SEQ_W-1:0]  rd_seq;

    adc_reg_bus u_bus (
        .clk        (clk),
        .reset      (reset),
        .addr       (addr),
        .wdata      (wdata),
        .wr         (wr),
        .re         (re),
        .rdata      (data_out),
        .busy       (busy),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .cmd_ready  (cmd_ready),
        .rate_wr    (rate_wr),
        .rate_chan  (rate_chan),
        .rate_value (rate_value),
        .rd_chan    (rd_chan),
        .rd_sample  (rd_sample),
        .rd_seq     (rd_seq)
    );

    adc_serial_link u_link (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .cmd_ready   (cmd_ready),
        .frame_valid (link_valid),
        .frame_data  (link_data),
        .frame_ready (link_ready),
        .adc_cs_n    (adc_cs_n),
        .adc_sclk    (adc_sclk),
        .adc_din     (adc_din),
        .adc_dout    (adc_dout)
    );

    frame_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (link_valid),
        .in_ready  (link_ready),
        .in_data   (link_data),
        .out_valid (bank_valid),
        .out_ready (bank_ready),
        .out_data  (bank_data)
    );

    adc_sample_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .frame_valid (bank_valid),
        .frame_ready (bank_ready),
        .frame_data  (bank_data),
        .rate_wr     (rate_wr),
        .rate_chan   (rate_chan),
        .rate_value  (rate_value),
        .rd_chan     (rd_chan),
        .rd_sample   (rd_sample),
        .rd_seq      (rd_seq)
    );

endmodule

// File: rtl/adc_reg_bus.sv
`timescale 1ns/1ns

module adc_reg_bus
    import adc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [15:0]       addr,
    input  logic [31:0]       wdata,
    input  logic              wr,
    input  logic              re,
    output logic [15:0]       rdata,
    output logic              busy,
    output logic              cmd_valid,
    output logic [15:0]       cmd_word,
    input  logic              cmd_ready,
    output logic              rate_wr,
    output logic [CHAN_W-1:0] rate_chan,
    output logic [RATE_W-1:0] rate_value,
    output logic [CHAN_W-1:0] rd_chan,
    input  frame_t            rd_sample,
    input  logic [SEQ_W-1:0]  rd_seq
);

    logic [7:0]        offset;
    logic [7:0]        chan_field;
    logic              chan_ok;
    logic              cmd_take;
    logic              program_wr;
    logic [15:0]       last_q;
    logic [BUSY_W-1:0] busy_cnt;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    // addr[15:8] picks the channel, addr[7:0] the register
    assign offset     = addr[7:0];
    assign chan_field = addr[15:8];
    // channels eight and up are ignored
    assign chan_ok    = (chan_field < 8'(NUM_CHANNELS));
    assign rd_chan    = chan_field[CHAN_W-1:0];

    assign rate_wr    = wr & chan_ok & (offset == REG_RATE);
    assign rate_chan  = chan_field[CHAN_W-1:0];
    assign rate_value = wdata;

    assign program_wr = wr & chan_ok & (offset == REG_PROGRAM) &
                        (wdata[31:16] == CMD_NEW_VALUE);
    assign cmd_take   = cmd_valid & cmd_ready;
    // high while pending or while the link shifts it out
    assign busy       = cmd_valid | (busy_cnt != '0);

    // --------------------------------------------------
    // command hand-off
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_valid <= 1'b0;
            busy_cnt  <= '0;
            last_q    <= '0;
        end else begin
            if (program_wr) begin
                cmd_valid <= 1'b1;
            end else if (cmd_take) begin
                cmd_valid <= 1'b0;
            end
            // link shifts for XFER_CYCLES after the hand-off
            if (cmd_take) begin
                busy_cnt <= BUSY_W'(XFER_CYCLES);
                last_q   <= cmd_word;
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    // command word captured with each accepted PROGRAM write
    always_ff @(posedge clk) begin
        if (program_wr) begin
            cmd_word <= wdata[15:0];
        end
    end

    // read data one cycle after re and zero without a read
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (re && chan_ok) begin
            case (offset)
                REG_SAMPLE:   rdata <= rd_sample;
                REG_SEQUENCE: rdata <= rd_seq;
                REG_ID:       rdata <= ID_VALUE;
                REG_LAST:     rdata <= last_q;
                default:      rdata <= '0;
            endcase
        end else begin
            rdata <= '0;
        end
    end

endmodule

// File: rtl/frame_fifo.sv
`timescale 1ns/1ns

module frame_fifo
    import adc_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    output logic   in_ready,
    input  frame_t in_data,
    output logic   out_valid,
    input  logic   out_ready,
    output frame_t out_data
);

    frame_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    // head entry shows one cycle after its push
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // --------------------------------------------------
    // pointers and fill level
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // explicit wrap so the depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: sim/adc_chip_model.sv
`timescale 1ns/1ns

module adc_chip_model
    import adc_pkg::*;
(
    input  logic                                 clk,
    input  logic [NUM_CHANNELS-1:0][FRAME_BITS-1:0] frame_table,
    input  logic                                 adc_cs_n,
    input  logic                                 adc_sclk,
    input  logic                                 adc_din,
    output logic                                 adc_dout,
    output logic [15:0]                          last_cmd
);

    // pin levels seen on the previous clk edge
    logic              cs_q      = 1'b1;
    logic              sclk_q    = 1'b0;
    // channel sent in the next transfer cycles through 0..7
    logic [CHAN_W-1:0] next_chan = '0;
    frame_t            tx_shift  = '0;
    logic [15:0]       rx_shift  = '0;
    logic [15:0]       cmd_q     = '0;

    // --------------------------------------------------
    // pin oversampling with clk
    // --------------------------------------------------
    // edges are seen one clk late and still a full cycle before the link samples
    always @(posedge clk) begin
        cs_q   <= adc_cs_n;
        sclk_q <= adc_sclk;
        if (cs_q && !adc_cs_n) begin
            // start of transfer loads the frame with the channel in the top bits
            tx_shift  <= {next_chan, frame_table[next_chan][FRAME_BITS-CHAN_W-1:0]};
            rx_shift  <= '0;
            next_chan <= next_chan + 1'b1;
        end else if (!cs_q && adc_cs_n) begin
            // a read shifts in all zeros so only a nonzero word is a command
            if (rx_shift != '0) begin
                cmd_q <= rx_shift;
            end
        end else if (!adc_cs_n && sclk_q && !adc_sclk) begin
            // next bit out on falling sclk
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
        end else if (!adc_cs_n && !sclk_q && adc_sclk) begin
            // take din msb first on rising sclk
            rx_shift <= {rx_shift[FRAME_BITS-2:0], adc_din};
        end
    end

    assign adc_dout = tx_shift[FRAME_BITS-1];
    assign last_cmd = cmd_q;

endmodule

// File: sim/tb_adc_control.sv
`timescale 1ns/1ns

module tb_adc_control
    import adc_pkg::*;
();

    localparam logic [15:0] CMD_LOW = 16'hA5C3;
    // two full rounds of transfers over all channels
    localparam int ROUND_CYCLES = 2 * NUM_CHANNELS * (XFER_CYCLES + 4 * SCLK_DIV);

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic        wr;
    logic        re;
    logic        run;
    logic [15:0] data_out;
    logic        busy;
    logic        adc_cs_n;
    logic        adc_sclk;
    logic        adc_din;
    logic        adc_dout;

    logic [NUM_CHANNELS-1:0][FRAME_BITS-1:0] chip_table;
    logic [15:0]       chip_last_cmd;
    integer            seed;
    int                value_errors;
    int                sample_errors;
    int                other_errors;
    string             test_name;
    // flags a SAMPLE read for the compare process
    logic              check_sample;
    logic              check_q;
    logic [CHAN_W-1:0] check_chan_q;

    always #50 clk = ~clk;

    adc_control_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .addr     (addr),
        .wdata    (wdata),
        .wr       (wr),
        .re       (re),
        .data_out (data_out),
        .busy     (busy),
        .run      (run),
        .adc_cs_n (adc_cs_n),
        .adc_sclk (adc_sclk),
        .adc_din  (adc_din),
        .adc_dout (adc_dout)
    );

    adc_chip_model chip0 (
        .clk         (clk),
        .frame_table (chip_table),
        .adc_cs_n    (adc_cs_n),
        .adc_sclk    (adc_sclk),
        .adc_din     (adc_din),
        .adc_dout    (adc_dout),
        .last_cmd    (chip_last_cmd)
    );

    // --------------------------------------------------
    // reference, compare tasks and bus helpers
    // --------------------------------------------------
    // table value with the channel forced into bits 15..13
    function automatic frame_t expected_sample(input logic [CHAN_W-1:0] ch);
        return {ch, chip_table[ch][FRAME_BITS-CHAN_W-1:0]};
    endfunction

    function automatic logic [15:0] reg_addr(input int ch, input logic [7:0] offset);
        return {8'(ch), offset};
    endfunction

    task automatic check_word(input string what, input frame_t exp, input frame_t act,
                              inout int errs);
        if (act !== exp) begin
            errs++;
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_seq(input string what, input logic [SEQ_W-1:0] exp,
                             input logic [SEQ_W-1:0] act, inout int errs);
        if (act !== exp) begin
            errs++;
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // caller sits on a rising edge
    task automatic fill_table();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            chip_table[CHAN_W'(i)] <= 16'($random(seed));
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge clk);
        wr <= 1'b0;
    endtask

    // data_out is registered and taken mid cycle after re
    task automatic bus_read(input logic [15:0] a, input logic flag, output logic [15:0] value);
        @(posedge clk);
        addr         <= a;
        re           <= 1'b1;
        check_sample <= flag;
        @(posedge clk);
        re           <= 1'b0;
        check_sample <= 1'b0;
        @(negedge clk);
        value = data_out;
    endtask

    task automatic wait_busy_low(input int max_cycles);
        int n;
        n = 0;
        while (busy && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            other_errors++;
            $display("timeout in %s: busy stayed high for %0d cycles", test_name, max_cycles);
        end
    endtask

    // polls SEQUENCE every two cycles until it differs from old
    task automatic wait_seq_change(input int ch, input logic [SEQ_W-1:0] old,
                                   output logic [SEQ_W-1:0] now);
        int          polls;
        logic [15:0] rd;
        polls = 0;
        bus_read(reg_addr(ch, REG_SEQUENCE), 1'b0, rd);
        while (rd == old && polls < 2000) begin
            bus_read(reg_addr(ch, REG_SEQUENCE), 1'b0, rd);
            polls++;
        end
        if (rd == old) begin
            other_errors++;
            $display("timeout in %s: sequence of channel %0d stuck at %0d", test_name, ch, old);
        end
        now = rd;
    endtask

    // compare process checks every flagged SAMPLE read against the reference
    always @(posedge clk) begin
        check_q      <= re & check_sample;
        check_chan_q <= addr[8 +: CHAN_W];
    end

    always @(negedge clk) begin
        if (check_q) begin
            check_word("sample", expected_sample(check_chan_q), data_out, sample_errors);
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        logic [15:0]      rd;
        logic [SEQ_W-1:0] s1;
        logic [SEQ_W-1:0] s2;
        bit               busy_seen;
        seed          = 32'hdf1;
        value_errors  = 0;
        sample_errors = 0;
        other_errors  = 0;
        test_name     = "reset";
        clk           = 1'b0;
        reset         = 1'b1;
        addr          = '0;
        wdata         = '0;
        wr            = 1'b0;
        re            = 1'b0;
        run           = 1'b0;
        check_sample  = 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        if (adc_cs_n !== 1'b1) begin
            other_errors++;
            $display("adc_cs_n is low during reset");
        end
        @(posedge clk);
        reset <= 1'b0;
        fill_table();

        // id, cleared registers, busy low
        bus_read(reg_addr(0, REG_ID), 1'b0, rd);
        check_word("id", ID_VALUE, rd, value_errors);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            bus_read(reg_addr(ch, REG_SAMPLE), 1'b0, rd);
            check_word("sample after reset", '0, rd, value_errors);
            bus_read(reg_addr(ch, REG_SEQUENCE), 1'b0, rd);
            check_seq("sequence after reset", '0, rd, value_errors);
        end
        if (busy) begin
            other_errors++;
            $display("busy is high after reset");
        end

        // command shift-out
        test_name = "program";
        bus_write(reg_addr(0, REG_PROGRAM), {CMD_NEW_VALUE, CMD_LOW});
        @(negedge clk);
        if (!busy) begin
            other_errors++;
            $display("busy did not rise after a PROGRAM write");
        end
        wait_busy_low(400);
        repeat (4) @(negedge clk);
        check_word("chip command", CMD_LOW, chip_last_cmd, value_errors);
        bus_read(reg_addr(0, REG_LAST), 1'b0, rd);
        check_word("last", CMD_LOW, rd, value_errors);
        // wrong upper half is not a command
        bus_write(reg_addr(0, REG_PROGRAM), {16'h0002, 16'h1234});
        busy_seen = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            busy_seen = busy_seen | busy;
        end
        if (busy_seen) begin
            other_errors++;
            $display("busy rose after a PROGRAM word without the command marker");
        end
        bus_read(reg_addr(0, REG_LAST), 1'b0, rd);
        check_word("last kept", CMD_LOW, rd, value_errors);

        // rate setup with channel 7 left disabled
        test_name = "first sample";
        for (int ch = 0; ch < NUM_CHANNELS - 1; ch++) begin
            bus_write(reg_addr(ch, REG_RATE), 32'(700 + 50 * ch));
        end
        bus_write(reg_addr(NUM_CHANNELS - 1, REG_RATE), 32'd0);
        @(posedge clk);
        run <= 1'b1;
        for (int ch = 0; ch < NUM_CHANNELS - 1; ch++) begin
            wait_seq_change(ch, '0, s1);
            bus_read(reg_addr(ch, REG_SAMPLE), 1'b1, rd);
        end

        // sequence steps by one per rate period
        test_name = "sequence rise";
        for (int ch = 0; ch < NUM_CHANNELS - 1; ch += 3) begin
            bus_read(reg_addr(ch, REG_SEQUENCE), 1'b0, s1);
            wait_seq_change(ch, s1, s2);
            check_seq("step", s1 + 1'b1, s2, value_errors);
        end
        bus_read(reg_addr(NUM_CHANNELS - 1, REG_SEQUENCE), 1'b0, rd);
        check_seq("rate zero", '0, rd, value_errors);

        // run low freezes the counters
        test_name = "run stop";
        @(posedge clk);
        run <= 1'b0;
        repeat (4) @(posedge clk);
        // short rate so a free-running counter would publish inside the window
        bus_write(reg_addr(0, REG_RATE), 32'd200);
        bus_read(reg_addr(0, REG_SEQUENCE), 1'b0, s1);
        repeat (500) @(posedge clk);
        bus_read(reg_addr(0, REG_SEQUENCE), 1'b0, s2);
        check_seq("stopped", s1, s2, value_errors);
        @(posedge clk);
        run <= 1'b1;
        wait_seq_change(0, s2, s1);
        check_seq("restart", s2 + 1'b1, s1, value_errors);

        // new frames must reach the bank through the fifo
        test_name = "new table";
        @(posedge clk);
        fill_table();
        repeat (ROUND_CYCLES) @(posedge clk);
        for (int ch = 0; ch < NUM_CHANNELS - 1; ch++) begin
            bus_read(reg_addr(ch, REG_SEQUENCE), 1'b0, s1);
            wait_seq_change(ch, s1, s2);
            bus_read(reg_addr(ch, REG_SAMPLE), 1'b1, rd);
        end

        repeat (4) @(posedge clk);
        $display("summary: %0d value errors, %0d sample errors, %0d other errors",
                 value_errors, sample_errors, other_errors);
        if (value_errors + sample_errors + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tb.f
common/adc_pkg.sv
adc/adc_serial_link.sv
rtl/frame_fifo.sv
adc/adc_sample_bank.sv
rtl/adc_reg_bus.sv
rtl/adc_control_top.sv
sim/adc_chip_model.sv
sim/tb_adc_control.sv
